/* include/rf_ecc_defs.svh */
// Sizes of the ECC-protected register file and the address width of its status block
// Included by the packages and by any module that sizes a port from these values

`ifndef RF_ECC_DEFS_SVH
`define RF_ECC_DEFS_SVH

// Number of general purpose registers, x0 included
`define RF_DEPTH 32

// Data bits per register
`define RF_DATA_W 32

// Check bits per register
`define RF_ECC_W 6

// Full codeword with the check bits stacked above the data bits
`define RF_CW_W 38

// Inversion applied to the raw parity so that a zero register encodes to 6'h2a
`define RF_ZERO_ECC 6'h2a

// Byte address width of the AXI4-Lite status block
`define CSR_ADDR_W 4

`endif

/* source/rf_ecc_pkg.sv */
// Codeword types and the check-bit encoder shared by the register storage and the read checkers
// Modules pull these in with a wildcard import in their header
`default_nettype none
`include "rf_ecc_defs.svh"

package rf_ecc_pkg;

  typedef logic [`RF_DATA_W-1:0]        rf_data_t;
  typedef logic [`RF_ECC_W-1:0]         rf_ecc_t;
  typedef logic [$clog2(`RF_DEPTH)-1:0] rf_addr_t;

  // Check bits occupy the top of the word, data the bottom
  typedef struct packed {
    rf_ecc_t  ecc;
    rf_data_t data;
  } rf_codeword_t;

  // Encoded form of a zero register, which is also the reset value
  localparam rf_codeword_t RF_CW_ZERO = '{ecc: `RF_ZERO_ECC, data: '0};

  // Data bit idx takes the idx-th check-width value of weight two or more, counting upward
  // Distinct columns of weight >= 2 keep every single and double flip off a zero syndrome
  function automatic rf_ecc_t rf_ecc_column(input int unsigned idx);
    rf_ecc_t     col;
    rf_ecc_t     cand;
    int unsigned seen;
    col  = '0;
    seen = 0;
    for (int v = 0; v < (1 << `RF_ECC_W); v++) begin
      cand = rf_ecc_t'(v);
      if ($countones(cand) >= 2) begin
        if (seen == idx) col = cand;
        seen++;
      end
    end
    return col;
  endfunction

  // Check bit k is the XOR of every data bit whose column has bit k set
  function automatic rf_ecc_t rf_ecc_compute(input rf_data_t data);
    rf_ecc_t parity;
    rf_ecc_t col;
    parity = '0;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      col = rf_ecc_column(i);
      for (int k = 0; k < `RF_ECC_W; k++) begin
        if (col[k]) parity[k] = parity[k] ^ data[i];
      end
    end
    // Inverted bits keep all-zero and all-one words out of the legal code
    return parity ^ `RF_ZERO_ECC;
  endfunction

endpackage

`default_nettype wire

/* source/rf_csr_pkg.sv */
// Types of the AXI4-Lite status block: register offsets, responses and channel states
// Imported by the status block and by the top level for its response ports
`default_nettype none
`include "rf_ecc_defs.svh"

package rf_csr_pkg;

  // Byte offsets of the status registers
  typedef enum logic [`CSR_ADDR_W-1:0] {
    CSR_STATUS    = 4'h0,
    CSR_ERR_COUNT = 4'h4,
    CSR_ERR_INFO  = 4'h8,
    CSR_CTRL      = 4'hC
  } csr_reg_e;

  // Only the two responses this slave can give
  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_SLVERR = 2'b10
  } axi_resp_e;

  // Write side collects AW and W, then holds B until accepted
  typedef enum logic {
    CSR_WR_IDLE,
    CSR_WR_RESP
  } csr_wr_state_e;

  // Read side takes one AR, then holds R until accepted
  typedef enum logic {
    CSR_RD_IDLE,
    CSR_RD_RESP
  } csr_rd_state_e;

endpackage

`default_nettype wire

/* source/rf_ecc_regfile.sv */
// Storage of the 32 encoded registers with writeback, fault injection and two raw read ports
// Read codewords go out unchecked; the checkers sit outside
`timescale 1ns/1ps
`default_nettype none
`include "rf_ecc_defs.svh"

module rf_ecc_regfile
  import rf_ecc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         we_i,
  input  rf_addr_t     waddr_i,
  input  rf_data_t     wdata_i,
  input  rf_addr_t     raddr_a_i,
  input  rf_addr_t     raddr_b_i,
  input  logic         fault_en_i,
  input  rf_addr_t     fault_addr_i,
  input  rf_codeword_t fault_mask_i,
  output rf_codeword_t cw_a,
  output rf_codeword_t cw_b
);

  rf_codeword_t mem [`RF_DEPTH];
  rf_codeword_t wr_cw;

  // Encode the writeback data once for whichever register it lands in
  assign wr_cw = '{ecc: rf_ecc_compute(wdata_i), data: wdata_i};

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      // Every register comes out of reset holding zero with its proper check bits
      for (int i = 0; i < `RF_DEPTH; i++) begin
        mem[i] <= RF_CW_ZERO;
      end
    end else begin
      for (int i = 0; i < `RF_DEPTH; i++) begin
        if (we_i && (waddr_i == rf_addr_t'(i)) && (i != 0)) begin
          // A fault hitting the same register lands on top of the fresh codeword
          if (fault_en_i && (fault_addr_i == rf_addr_t'(i))) begin
            mem[i] <= wr_cw ^ fault_mask_i;
          end else begin
            mem[i] <= wr_cw;
          end
        end else if (fault_en_i && (fault_addr_i == rf_addr_t'(i))) begin
          // x0 is not protected from upsets, only from writes
          mem[i] <= mem[i] ^ fault_mask_i;
        end
      end
    end
  end

  // Raw codewords for both source operands appear in the same cycle as the address
  assign cw_a = mem[raddr_a_i];
  assign cw_b = mem[raddr_b_i];

  // A writeback to x0 must leave its codeword as it was, unless a fault hits it
  a_x0_write_ignored: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (we_i && (waddr_i == '0) && !(fault_en_i && (fault_addr_i == '0)))
    |=> (mem[0] == $past(mem[0])));

endmodule

`default_nettype wire

/* source/rf_ecc_checker.sv */
// Combinational checker for one read port of the register file
// Splits off the data and flags any codeword whose check bits do not match or that is illegal
`timescale 1ns/1ps
`default_nettype none

module rf_ecc_checker
  import rf_ecc_pkg::*;
(
  input  rf_codeword_t cw,
  output rf_data_t     rdata,
  output rf_ecc_t      syndrome,
  output logic         err
);

  logic all_zero;
  logic all_one;

  // The operand leaves the port whatever the check finds, since the block only detects
  assign rdata = cw.data;

  always_comb begin
    // Recompute the check bits and compare against the stored ones
    syndrome = rf_ecc_compute(cw.data) ^ cw.ecc;

    // Stuck-at patterns across the whole word are never legal
    all_zero = ~(|cw);
    all_one  = &cw;

    // Any flip of one or two bits gives a nonzero syndrome
    err = (syndrome != '0) || all_zero || all_one;

    // Illegal words must already fail the parity, which the inverted check bits guarantee
    if ((cw == '0) || (cw == '1)) begin
      a_illegal_flagged: assert (syndrome != '0);
    end
  end

endmodule

`default_nettype wire

/* source/rf_alert_csr.sv */
// AXI4-Lite status block: sticky major alert, saturating error count and last-error record
// Fed by the two read checkers; CTRL bit 0 clears everything
`timescale 1ns/1ps
`default_nettype none
`include "rf_ecc_defs.svh"

module rf_alert_csr
  import rf_ecc_pkg::*;
  import rf_csr_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   re_a,
  input  logic                   err_a,
  input  rf_addr_t               raddr_a,
  input  rf_ecc_t                syndrome_a,
  input  logic                   re_b,
  input  logic                   err_b,
  input  rf_addr_t               raddr_b,
  input  rf_ecc_t                syndrome_b,
  input  logic [`CSR_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output axi_resp_e              bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [`CSR_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output axi_resp_e              rresp,
  output logic                   rvalid,
  input  logic                   rready,
  output logic                   alert_major_o
);

  logic                   qual_a;
  logic                   qual_b;
  logic [1:0]             n_err;
  logic [15:0]            err_count;
  logic [15:0]            count_base;
  logic [16:0]            count_sum;
  logic                   last_port;
  rf_addr_t               last_addr;
  rf_ecc_t                last_syn;
  csr_wr_state_e          wr_state;
  csr_rd_state_e          rd_state;
  logic                   aw_got;
  logic                   w_got;
  logic [`CSR_ADDR_W-1:0] awaddr_q;
  logic [31:0]            wdata_q;
  logic [3:0]             wstrb_q;
  logic                   wr_fire;
  logic                   wr_ok;
  logic                   clr;
  logic [31:0]            rd_value;
  axi_resp_e              rd_resp;

  // A checker error only counts when its port is really reading
  assign qual_a = re_a && err_a;
  assign qual_b = re_b && err_b;
  assign n_err  = {1'b0, qual_a} + {1'b0, qual_b};

  // Write is carried out in the cycle both halves are held
  assign wr_fire = (wr_state == CSR_WR_IDLE) && aw_got && w_got;

  always_comb begin
    wr_ok = 1'b0;
    clr   = 1'b0;
    // CTRL is the only writable offset and everything else answers SLVERR
    case (awaddr_q)
      CSR_CTRL: begin
        wr_ok = 1'b1;
        clr   = wr_fire && wstrb_q[0] && wdata_q[0];
      end
      default: ;
    endcase
  end

  // A clear in the same cycle as an error restarts the count from the new errors
  assign count_base = clr ? '0 : err_count;
  assign count_sum  = {1'b0, count_base} + 17'(n_err);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      alert_major_o <= 1'b0;
      err_count     <= '0;
      last_port     <= 1'b0;
      last_addr     <= '0;
      last_syn      <= '0;
    end else begin
      alert_major_o <= qual_a || qual_b || (alert_major_o && !clr);
      err_count     <= count_sum[16] ? 16'hffff : count_sum[15:0];
      // Port A wins the record when both ports fail together
      if (qual_a) begin
        last_port <= 1'b0;
        last_addr <= raddr_a;
        last_syn  <= syndrome_a;
      end else if (qual_b) begin
        last_port <= 1'b1;
        last_addr <= raddr_b;
        last_syn  <= syndrome_b;
      end else if (clr) begin
        last_port <= 1'b0;
        last_addr <= '0;
        last_syn  <= '0;
      end
    end
  end

  // Captured AW and W payloads
  always_ff @(posedge clk_i) begin
    if (awvalid && awready) awaddr_q <= awaddr;
    if (wvalid && wready) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
  end

  // Write channel FSM taking AW and W independently, one of each
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_state <= CSR_WR_IDLE;
      awready  <= 1'b0;
      wready   <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      bvalid   <= 1'b0;
      bresp    <= AXI_OKAY;
    end else begin
      case (wr_state)
        CSR_WR_IDLE: begin
          if (awvalid && awready) begin
            aw_got  <= 1'b1;
            awready <= 1'b0;
          end else begin
            awready <= !aw_got;
          end
          if (wvalid && wready) begin
            w_got  <= 1'b1;
            wready <= 1'b0;
          end else begin
            wready <= !w_got;
          end
          if (wr_fire) begin
            bvalid   <= 1'b1;
            bresp    <= wr_ok ? AXI_OKAY : AXI_SLVERR;
            wr_state <= CSR_WR_RESP;
          end
        end
        CSR_WR_RESP: begin
          // Nothing new is accepted while B is stalled
          if (bready) begin
            bvalid   <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            wr_state <= CSR_WR_IDLE;
          end
        end
        default: wr_state <= CSR_WR_IDLE;
      endcase
    end
  end

  always_comb begin
    rd_value = '0;
    rd_resp  = AXI_OKAY;
    case (araddr)
      CSR_STATUS:    rd_value = {30'd0, last_port, alert_major_o};
      CSR_ERR_COUNT: rd_value = {16'd0, err_count};
      CSR_ERR_INFO:  rd_value = {18'd0, last_syn, 3'd0, last_addr};
      // CTRL is write-to-act and reads back as zero
      CSR_CTRL:      rd_value = '0;
      default:       rd_resp = AXI_SLVERR;
    endcase
  end

  // Read channel FSM serving one AR at a time
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_state <= CSR_RD_IDLE;
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rdata    <= '0;
      rresp    <= AXI_OKAY;
    end else begin
      case (rd_state)
        CSR_RD_IDLE: begin
          if (arvalid && arready) begin
            arready  <= 1'b0;
            rvalid   <= 1'b1;
            rdata    <= rd_value;
            rresp    <= rd_resp;
            rd_state <= CSR_RD_RESP;
          end else begin
            arready <= 1'b1;
          end
        end
        CSR_RD_RESP: begin
          if (rready) begin
            rvalid   <= 1'b0;
            rd_state <= CSR_RD_IDLE;
          end
        end
        default: rd_state <= CSR_RD_IDLE;
      endcase
    end
  end

  // Responses stay up with a steady payload until the master takes them
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bvalid && !bready) |=> (bvalid && $stable(bresp)));

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)));

  // The alert only ever rises on the edge after a read that failed its check
  a_alert_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(alert_major_o) |-> $past(qual_a || qual_b));

endmodule

`default_nettype wire

/* source/rf_ecc_top.sv */
// Top of the ECC-protected register file: storage, one checker per read port, status block
// Core-side ports are single-cycle strobes; status is read over AXI4-Lite
`timescale 1ns/1ps
`default_nettype none
`include "rf_ecc_defs.svh"

module rf_ecc_top
  import rf_ecc_pkg::*;
  import rf_csr_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   we_i,
  input  rf_addr_t               waddr_i,
  input  rf_data_t               wdata_i,
  input  logic                   re_a_i,
  input  rf_addr_t               raddr_a_i,
  input  logic                   re_b_i,
  input  rf_addr_t               raddr_b_i,
  input  logic                   fault_en_i,
  input  rf_addr_t               fault_addr_i,
  input  rf_codeword_t           fault_mask_i,
  output rf_data_t               rdata_a,
  output rf_data_t               rdata_b,
  input  logic [`CSR_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output axi_resp_e              bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [`CSR_ADDR_W-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output axi_resp_e              rresp,
  output logic                   rvalid,
  input  logic                   rready,
  output logic                   alert_major_o
);

  rf_codeword_t cw_a;
  rf_codeword_t cw_b;
  rf_ecc_t      syn_a;
  rf_ecc_t      syn_b;
  logic         err_a;
  logic         err_b;

  rf_ecc_regfile u_regfile (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .we_i         (we_i),
    .waddr_i      (waddr_i),
    .wdata_i      (wdata_i),
    .raddr_a_i    (raddr_a_i),
    .raddr_b_i    (raddr_b_i),
    .fault_en_i   (fault_en_i),
    .fault_addr_i (fault_addr_i),
    .fault_mask_i (fault_mask_i),
    .cw_a         (cw_a),
    .cw_b         (cw_b)
  );

  // rs1 side
  rf_ecc_checker u_chk_a (
    .cw       (cw_a),
    .rdata    (rdata_a),
    .syndrome (syn_a),
    .err      (err_a)
  );

  // rs2 side
  rf_ecc_checker u_chk_b (
    .cw       (cw_b),
    .rdata    (rdata_b),
    .syndrome (syn_b),
    .err      (err_b)
  );

  // Read strobes go along so idle ports never raise the alert
  rf_alert_csr u_csr (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .re_a          (re_a_i),
    .err_a         (err_a),
    .raddr_a       (raddr_a_i),
    .syndrome_a    (syn_a),
    .re_b          (re_b_i),
    .err_b         (err_b),
    .raddr_b       (raddr_b_i),
    .syndrome_b    (syn_b),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .bresp         (bresp),
    .bvalid        (bvalid),
    .bready        (bready),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready),
    .alert_major_o (alert_major_o)
  );

endmodule

`default_nettype wire

/* verif/tb_rf_ecc_top.sv */
// Self-checking testbench for the ECC-protected register file and its AXI4-Lite status block
// A shadow model of every codeword predicts read data, the alert and the status registers
`timescale 1ns/1ps
`default_nettype none
`include "rf_ecc_defs.svh"

module tb_rf_ecc_top;

  // Far more cycles than all six tests need together, so only a hang reaches it
  localparam int         CYCLE_LIMIT   = 20000;
  localparam logic [3:0] OFF_STATUS    = 4'h0;
  localparam logic [3:0] OFF_ERR_COUNT = 4'h4;
  localparam logic [3:0] OFF_ERR_INFO  = 4'h8;
  localparam logic [3:0] OFF_CTRL      = 4'hC;
  localparam logic [1:0] RESP_OKAY     = 2'b00;
  localparam logic [1:0] RESP_SLVERR   = 2'b10;

  logic                clk_i;
  logic                rst_ni;
  logic                we_i;
  logic [4:0]          waddr_i;
  logic [31:0]         wdata_i;
  logic                re_a_i;
  logic [4:0]          raddr_a_i;
  logic                re_b_i;
  logic [4:0]          raddr_b_i;
  logic                fault_en_i;
  logic [4:0]          fault_addr_i;
  logic [`RF_CW_W-1:0] fault_mask_i;
  logic [31:0]         rdata_a;
  logic [31:0]         rdata_b;
  logic [3:0]          awaddr;
  logic                awvalid;
  logic                awready;
  logic [31:0]         wdata;
  logic [3:0]          wstrb;
  logic                wvalid;
  logic                wready;
  logic [1:0]          bresp;
  logic                bvalid;
  logic                bready;
  logic [3:0]          araddr;
  logic                arvalid;
  logic                arready;
  logic [31:0]         rdata;
  logic [1:0]          rresp;
  logic                rvalid;
  logic                rready;
  logic                alert_major_o;

  // Shadow codewords and the expected status block contents
  logic [`RF_CW_W-1:0] model_cw [`RF_DEPTH];
  logic                alert_exp;
  logic [15:0]         count_exp;
  logic                port_exp;
  logic [4:0]          addr_exp;
  logic [5:0]          syn_exp;
  logic                check_alert;
  logic [6:0]          res_a;
  logic [6:0]          res_b;
  logic                qual_a;
  logic                qual_b;
  int                  seed = 32'h2f4b_695c;
  int                  errors = 0;
  int                  test_errors = 0;
  int                  tests_failed = 0;
  int                  cycles = 0;

  rf_ecc_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Check bits straight from the column rule. Each 6-bit value of weight two or more, taken
  // upward, becomes the next data bit's column, and the set data bits' columns fold together
  function automatic logic [5:0] ref_ecc(input logic [31:0] d);
    logic [5:0] p;
    int         bit_idx;
    p = 6'h0;
    bit_idx = 0;
    for (int col = 0; col < 64; col++) begin
      if (($countones(col[5:0]) >= 2) && (bit_idx < 32)) begin
        if (d[bit_idx]) p = p ^ col[5:0];
        bit_idx++;
      end
    end
    return p ^ `RF_ZERO_ECC;
  endfunction

  // Returns the error flag above the syndrome
  function automatic logic [6:0] ref_check(input logic [`RF_CW_W-1:0] cw);
    logic [5:0] syn;
    logic       err;
    syn = ref_ecc(cw[31:0]) ^ cw[37:32];
    err = (syn != 6'h0) || (cw == '0) || (cw == '1);
    return {err, syn};
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic drive_cycle(input logic we, input logic [4:0] wa, input logic [31:0] wd,
                             input logic rea, input logic [4:0] ra, input logic reb,
                             input logic [4:0] rb, input logic fen, input logic [4:0] fa,
                             input logic [`RF_CW_W-1:0] fm);
    @(negedge clk_i);
    we_i         = we;
    waddr_i      = wa;
    wdata_i      = wd;
    re_a_i       = rea;
    raddr_a_i    = ra;
    re_b_i       = reb;
    raddr_b_i    = rb;
    fault_en_i   = fen;
    fault_addr_i = fa;
    fault_mask_i = fm;
  endtask

  // One quiet cycle, which also lets the compare process see the alert after a read
  task automatic drive_idle();
    drive_cycle(1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0, '0);
  endtask

  task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
    drive_cycle(1'b1, a, d, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 5'd0, '0);
    drive_idle();
  endtask

  task automatic inject(input logic [4:0] a, input logic [`RF_CW_W-1:0] m);
    drive_cycle(1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b1, a, m);
    drive_idle();
  endtask

  task automatic read_ports(input logic rea, input logic [4:0] ra,
                            input logic reb, input logic [4:0] rb);
    drive_cycle(1'b0, 5'd0, 32'd0, rea, ra, reb, rb, 1'b0, 5'd0, '0);
    drive_idle();
  endtask

  // Holds AW and W until each is taken, then takes the B response
  task automatic axi_write(input logic [3:0] a, input logic [31:0] d, output logic [1:0] resp);
    logic aw_done;
    logic w_done;
    logic b_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    b_done  = 1'b0;
    @(negedge clk_i);
    awaddr  = a;
    awvalid = 1'b1;
    wdata   = d;
    wstrb   = 4'hf;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (!b_done) begin
      @(posedge clk_i);
      if (awvalid && awready) aw_done = 1'b1;
      if (wvalid && wready) w_done = 1'b1;
      if (bvalid && bready) begin
        b_done = 1'b1;
        resp   = bresp;
      end
      @(negedge clk_i);
      if (aw_done) awvalid = 1'b0;
      if (w_done) wvalid = 1'b0;
    end
    bready = 1'b0;
  endtask

  // Holds AR until it is taken, then takes the R response
  task automatic axi_read(input logic [3:0] a, output logic [31:0] d, output logic [1:0] resp);
    logic ar_done;
    logic r_done;
    ar_done = 1'b0;
    r_done  = 1'b0;
    @(negedge clk_i);
    araddr  = a;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (!r_done) begin
      @(posedge clk_i);
      if (arvalid && arready) ar_done = 1'b1;
      if (rvalid && rready) begin
        r_done = 1'b1;
        d      = rdata;
        resp   = rresp;
      end
      @(negedge clk_i);
      if (ar_done) arvalid = 1'b0;
    end
    rready = 1'b0;
  endtask

  task automatic check_status_regs();
    logic [31:0] d;
    logic [1:0]  resp;
    axi_read(OFF_STATUS, d, resp);
    if ((resp !== RESP_OKAY) || (d !== {30'd0, port_exp, alert_exp}))
      report_mismatch($sformatf("STATUS read %h resp %b", d, resp));
    axi_read(OFF_ERR_COUNT, d, resp);
    if ((resp !== RESP_OKAY) || (d !== {16'd0, count_exp}))
      report_mismatch($sformatf("ERR_COUNT read %h, expected %h", d, count_exp));
    axi_read(OFF_ERR_INFO, d, resp);
    if ((resp !== RESP_OKAY) || (d !== {18'd0, syn_exp, 3'd0, addr_exp}))
      report_mismatch($sformatf("ERR_INFO read %h, expected addr %0d syn %h", d, addr_exp,
                                syn_exp));
  endtask

  task automatic clear_status();
    logic [1:0] resp;
    axi_write(OFF_CTRL, 32'h1, resp);
    if (resp !== RESP_OKAY) report_mismatch("CTRL clear did not return OKAY");
    alert_exp = 1'b0;
    count_exp = 16'd0;
    port_exp  = 1'b0;
    addr_exp  = 5'd0;
    syn_exp   = 6'd0;
    if (alert_major_o !== 1'b0) report_mismatch("alert still high after CTRL clear");
  endtask

  task automatic finish_test(input int num, input string name);
    if (errors == test_errors) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, errors - test_errors);
      tests_failed++;
    end
    test_errors = errors;
  endtask

  // Checks what the reads return, then advances the model by one edge
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      check_alert = 1'b0;
    end else begin
      if (check_alert && (alert_major_o !== alert_exp))
        report_mismatch($sformatf("alert_major_o is %b, expected %b", alert_major_o, alert_exp));
      check_alert = re_a_i || re_b_i;
      res_a  = ref_check(model_cw[raddr_a_i]);
      res_b  = ref_check(model_cw[raddr_b_i]);
      qual_a = re_a_i && res_a[6];
      qual_b = re_b_i && res_b[6];
      if (re_a_i && (rdata_a !== model_cw[raddr_a_i][31:0]))
        report_mismatch($sformatf("rdata_a x%0d is %h, expected %h", raddr_a_i, rdata_a,
                                  model_cw[raddr_a_i][31:0]));
      if (re_b_i && (rdata_b !== model_cw[raddr_b_i][31:0]))
        report_mismatch($sformatf("rdata_b x%0d is %h, expected %h", raddr_b_i, rdata_b,
                                  model_cw[raddr_b_i][31:0]));
      if (qual_a || qual_b) alert_exp = 1'b1;
      // The count saturates and port A owns the record when both fail
      if (int'(count_exp) + int'(qual_a) + int'(qual_b) > 65535) count_exp = 16'hffff;
      else count_exp = count_exp + 16'(qual_a) + 16'(qual_b);
      if (qual_a) begin
        port_exp = 1'b0;
        addr_exp = raddr_a_i;
        syn_exp  = res_a[5:0];
      end else if (qual_b) begin
        port_exp = 1'b1;
        addr_exp = raddr_b_i;
        syn_exp  = res_b[5:0];
      end
      // A write lands first and a fault in the same cycle flips it
      if (we_i && (waddr_i != 5'd0)) model_cw[waddr_i] = {ref_ecc(wdata_i), wdata_i};
      if (fault_en_i) model_cw[fault_addr_i] = model_cw[fault_addr_i] ^ fault_mask_i;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    int                  r;
    int                  r2;
    int                  p;
    int                  q;
    logic [31:0]         tmp;
    logic [31:0]         d;
    logic [1:0]          resp;
    logic [`RF_CW_W-1:0] mask;
    rst_ni       = 1'b0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    we_i         = 1'b0;
    waddr_i      = '0;
    wdata_i      = '0;
    re_a_i       = 1'b0;
    raddr_a_i    = '0;
    re_b_i       = 1'b0;
    raddr_b_i    = '0;
    fault_en_i   = 1'b0;
    fault_addr_i = '0;
    fault_mask_i = '0;
    for (int i = 0; i < `RF_DEPTH; i++) model_cw[i] = {`RF_ZERO_ECC, 32'h0};
    alert_exp = 1'b0;
    count_exp = 16'd0;
    port_exp  = 1'b0;
    addr_exp  = 5'd0;
    syn_exp   = 6'd0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    // Every register reads as zero out of reset
    for (int i = 0; i < `RF_DEPTH; i++) read_ports(1'b1, i[4:0], 1'b1, 5'(31 - i));
    if (alert_major_o !== 1'b0) report_mismatch("alert high after reset reads");
    check_status_regs();
    finish_test(1, "reset state");

    // Random traffic with x0 hit now and then, and once on purpose at the end
    for (int i = 0; i < 400; i++) begin
      tmp = rand_word();
      drive_cycle(tmp[0], tmp[9:5], rand_word(), tmp[1], tmp[14:10], tmp[2], tmp[19:15],
                  1'b0, 5'd0, '0);
    end
    write_reg(5'd0, 32'hdead_beef);
    read_ports(1'b1, 5'd0, 1'b1, 5'd0);
    if (alert_major_o !== 1'b0) report_mismatch("alert raised by clean traffic");
    check_status_regs();
    finish_test(2, "random writes and reads");

    // One or two flipped bits anywhere in the codeword, read on a random port
    for (int i = 0; i < 12; i++) begin
      clear_status();
      r    = 1 + int'(rand_word() % 32'd31);
      p    = int'(rand_word() % 32'd38);
      q    = (p + 1 + int'(rand_word() % 32'd37)) % 38;
      tmp  = rand_word();
      mask = '0;
      mask[p] = 1'b1;
      if (tmp[0]) mask[q] = 1'b1;
      inject(r[4:0], mask);
      if (tmp[1]) read_ports(1'b0, 5'd0, 1'b1, r[4:0]);
      else read_ports(1'b1, r[4:0], 1'b0, 5'd0);
      if (alert_major_o !== 1'b1) report_mismatch($sformatf("no alert for x%0d", r));
      axi_read(OFF_ERR_COUNT, d, resp);
      if (d !== 32'd1) report_mismatch($sformatf("ERR_COUNT is %0d after one upset", d));
      check_status_regs();
      write_reg(r[4:0], rand_word());
    end
    finish_test(3, "single and double bit upsets");

    // Whole codeword forced to all zeros, then all ones
    for (int kind = 0; kind < 2; kind++) begin
      clear_status();
      r    = 1 + int'(rand_word() % 32'd31);
      mask = (kind == 0) ? model_cw[r] : ~model_cw[r];
      inject(r[4:0], mask);
      read_ports(1'b1, r[4:0], 1'b0, 5'd0);
      if (alert_major_o !== 1'b1) report_mismatch("illegal codeword raised no alert");
      check_status_regs();
      write_reg(r[4:0], rand_word());
    end
    finish_test(4, "illegal codewords");

    // Both ports fail together, then clear and the error responses
    clear_status();
    r  = 1 + int'(rand_word() % 32'd31);
    r2 = 1 + ((r + int'(rand_word() % 32'd30)) % 31);
    mask = '0;
    mask[int'(rand_word() % 32'd38)] = 1'b1;
    inject(r[4:0], mask);
    inject(r2[4:0], mask);
    read_ports(1'b1, r[4:0], 1'b1, r2[4:0]);
    axi_read(OFF_ERR_COUNT, d, resp);
    if (d !== 32'd2) report_mismatch($sformatf("ERR_COUNT is %0d after two errors", d));
    axi_read(OFF_ERR_INFO, d, resp);
    if (d[4:0] !== r[4:0]) report_mismatch("ERR_INFO does not hold the port A address");
    check_status_regs();
    clear_status();
    check_status_regs();
    axi_write(OFF_ERR_COUNT, 32'h5, resp);
    if (resp !== RESP_SLVERR) report_mismatch("write to ERR_COUNT was not refused");
    axi_write(4'h6, 32'h1, resp);
    if (resp !== RESP_SLVERR) report_mismatch("write to an unmapped offset was not refused");
    axi_read(4'h2, d, resp);
    if (resp !== RESP_SLVERR) report_mismatch("read of an unmapped offset was not refused");
    check_status_regs();
    finish_test(5, "dual port errors and status access");

    // Fresh writes replace the corrupted codewords
    write_reg(r[4:0], rand_word());
    write_reg(r2[4:0], rand_word());
    read_ports(1'b1, r[4:0], 1'b1, r2[4:0]);
    if (alert_major_o !== 1'b0) report_mismatch("rewritten registers still raise an error");
    check_status_regs();
    finish_test(6, "rewrite after upset");

    $display("summary: 6 tests, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/rf_ecc_pkg.sv
source/rf_csr_pkg.sv
source/rf_ecc_regfile.sv
source/rf_ecc_checker.sv
source/rf_alert_csr.sv
source/rf_ecc_top.sv
verif/tb_rf_ecc_top.sv

/* Makefile */
# Verilator build and run for the ECC-protected register file testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_rf_ecc_top
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The run fails when the log holds the fail message or never reached the pass message
run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
